/* sim.f */
+incdir+bench
source/ncpu32k_div_pkg.sv
source/ncpu32k_cell_pipebuf.sv
source/ncpu32k_div_ctrl.sv
source/ncpu32k_div_iter_counter.sv
source/ncpu32k_div_datapath.sv
source/ncpu32k_div_unit.sv
bench/ncpu32k_div_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= ncpu32k_div_unit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

SOURCES := $(wildcard source/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the log holds the pass line.
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/ncpu32k_div_tests.svh */
`ifndef NCPU32K_DIV_TESTS_SVH
`define NCPU32K_DIV_TESTS_SVH

// ----------------------------------------------------------------------
// Compare and drive tasks
// ----------------------------------------------------------------------

task automatic check_word(input string name, input word_t got, input word_t exp);
   if (got !== exp) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      error_count++;
   end else begin
      pass_count++;
   end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
   end else begin
      pass_count++;
   end
endtask

// Offers one request and returns just after the edge that takes it.
task automatic send_req(input div_op_t kind, input word_t a, input word_t b);
   int waited;
   waited   = 0;
   in_valid = 1'b1;
   op       = kind;
   dividend = a;
   divisor  = b;
   while (!in_ready && waited < HANDSHAKE_LIMIT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
   end
   if (in_ready) begin
      @(posedge clk);
      #DRIVE_DELAY;
   end else begin
      $display("The unit did not accept a request within %0d cycles.", HANDSHAKE_LIMIT);
      error_count++;
   end
   in_valid = 1'b0;
endtask

// Raises out_ready, waits for a result and takes it.
task automatic get_result(output word_t value);
   int waited;
   waited    = 0;
   value     = '0;
   out_ready = 1'b1;
   while (!out_valid && waited < HANDSHAKE_LIMIT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
   end
   if (out_valid) begin
      value = result;
      @(posedge clk);
      #DRIVE_DELAY;
   end else begin
      $display("No result arrived within %0d cycles.", HANDSHAKE_LIMIT);
      error_count++;
   end
endtask

task automatic run_div(input div_op_t kind, input word_t a, input word_t b);
   word_t got;
   send_req(kind, a, b);
   get_result(got);
   check_word("result", got, expected_result(kind, a, b));
endtask

task automatic report_test(input string name, input int errors_before);
   $display("Test %s done with %0d errors", name, error_count - errors_before);
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------

task automatic test_reset_state();
   int errors_before;
   errors_before = error_count;
   check_bit("out_valid", out_valid, 1'b0);
   check_bit("retire", retire, 1'b0);
   check_bit("in_ready", in_ready, 1'b1);
   report_test("reset_state", errors_before);
endtask

// Four fixed pairs, then eight from the LFSR with smaller divisors.
task automatic test_unsigned();
   word_t a_list[4] = '{32'd100, 32'hffff_ffff, 32'h8000_0000, 32'd5};
   word_t b_list[4] = '{32'd7, 32'd3, 32'hffff_ffff, 32'd9};
   int    errors_before;
   word_t a;
   word_t b;
   errors_before = error_count;
   for (int i = 0; i < 12; i++) begin
      if (i < 4) begin
         a = a_list[i];
         b = b_list[i];
      end else begin
         a = rand_bits(XLEN);
         b = rand_bits(XLEN) >> rand_bits(5);
      end
      run_div(op_divu, a, b);
      run_div(op_remu, a, b);
   end
   report_test("unsigned", errors_before);
endtask

// All four sign combinations of 7 and 2, the overflow case, then LFSR.
task automatic test_signed();
   word_t a_list[5] = '{32'd7, 32'hffff_fff9, 32'd7, 32'hffff_fff9, 32'h8000_0000};
   word_t b_list[5] = '{32'd2, 32'd2, 32'hffff_fffe, 32'hffff_fffe, 32'hffff_ffff};
   int    errors_before;
   word_t a;
   word_t b;
   errors_before = error_count;
   for (int i = 0; i < 9; i++) begin
      if (i < 5) begin
         a = a_list[i];
         b = b_list[i];
      end else begin
         a = rand_bits(XLEN);
         b = $signed(rand_bits(XLEN)) >>> rand_bits(5);
      end
      run_div(op_div, a, b);
      run_div(op_rem, a, b);
   end
   report_test("signed", errors_before);
endtask

task automatic test_div_zero();
   div_op_t kinds[4]  = '{op_div, op_divu, op_rem, op_remu};
   word_t   a_list[2] = '{32'd1234, 32'hffff_fff6};
   int      errors_before;
   word_t   got;
   word_t   exp;
   errors_before = error_count;
   for (int i = 0; i < 2; i++) begin
      for (int k = 0; k < 4; k++) begin
         // A quotient becomes all ones and a remainder the dividend.
         if (kinds[k] == op_div || kinds[k] == op_divu) begin
            exp = '1;
         end else begin
            exp = a_list[i];
         end
         send_req(kinds[k], a_list[i], '0);
         get_result(got);
         check_word("result", got, exp);
      end
   end
   report_test("div_zero", errors_before);
endtask

task automatic test_latency();
   int    errors_before;
   int    cycles;
   word_t got;
   errors_before = error_count;
   out_ready     = 1'b1;
   send_req(op_divu, 32'd1000, 32'd7);
   // Count edges after the accepting edge until the result shows.
   cycles = 0;
   while (!out_valid && cycles < HANDSHAKE_LIMIT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
   end
   check_word("latency", word_t'(cycles), word_t'(EXPECTED_LATENCY));
   get_result(got);
   check_word("result", got, expected_result(op_divu, 32'd1000, 32'd7));
   report_test("latency", errors_before);
endtask

task automatic test_backpressure();
   div_op_t kinds[3] = '{op_div, op_remu, op_rem};
   word_t   a_list[3];
   word_t   b_list[3];
   word_t   got;
   int      errors_before;
   int      retired_before;
   errors_before  = error_count;
   retired_before = retire_count;
   out_ready      = 1'b0;
   for (int i = 0; i < 3; i++) begin
      a_list[i] = rand_bits(XLEN);
      b_list[i] = rand_bits(XLEN) >> rand_bits(4);
      send_req(kinds[i], a_list[i], b_list[i]);
   end
   // One result waits in the output buffer, one in the datapath and the
   // last request in the input buffer.
   check_bit("in_ready", in_ready, 1'b0);
   repeat (CYCLES_PER_DIV) @(posedge clk);
   #DRIVE_DELAY;
   check_bit("in_ready", in_ready, 1'b0);
   check_bit("out_valid", out_valid, 1'b1);
   for (int i = 0; i < 3; i++) begin
      get_result(got);
      check_word("result", got, expected_result(kinds[i], a_list[i], b_list[i]));
   end
   check_word("retire count", word_t'(retire_count - retired_before), word_t'(3));
   report_test("backpressure", errors_before);
endtask

`endif

/* bench/ncpu32k_div_unit_tb.sv */
`timescale 1ns/1ps

// ----------------------------------------------------------------------
// Testbench of the integer divide unit.
// ----------------------------------------------------------------------

module ncpu32k_div_unit_tb;
   import ncpu32k_div_pkg::*;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 10;
   localparam int DRIVE_DELAY  = 1;

   // Edges from the accepting edge of the input buffer to out_valid.
   localparam int EXPECTED_LATENCY = 35;

   // Divisions issued by the whole sequence. The stall in the
   // back-pressure test counts as one more division.
   localparam int NUM_DIVS        = 55;
   localparam int CYCLES_PER_DIV  = 40;
   localparam int WATCHDOG_CYCLES = NUM_DIVS * CYCLES_PER_DIV + 500;

   // Longest wait on a single handshake, which covers a full division.
   localparam int HANDSHAKE_LIMIT = 100;

   localparam logic [31:0] LFSR_SEED = 32'hd644_32e8;
   localparam word_t       MOST_NEG  = 32'h8000_0000;

   logic    clk;
   logic    reset;
   logic    in_valid;
   logic    in_ready;
   div_op_t op;
   word_t   dividend;
   word_t   divisor;
   logic    out_valid;
   logic    out_ready;
   word_t   result;
   logic    retire;

   int          error_count  = 0;
   int          pass_count   = 0;
   int          retire_count = 0;
   logic [31:0] lfsr_state;

   ncpu32k_div_unit #(
      .PIPEBUF_BYPASS (1'b1)
   ) i_dut (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .op        (op),
      .dividend  (dividend),
      .divisor   (divisor),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .result    (result),
      .retire    (retire)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // Retire is stable by the falling edge, so it is counted there.
   always @(negedge clk) begin
      if (!reset && retire) begin
         retire_count++;
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles before the tests ended.", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   // -------------------------------------------------------------------
   // Random numbers and reference model
   // -------------------------------------------------------------------

   // Fibonacci LFSR with taps 32, 22, 2 and 1.
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic feedback;
      feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], feedback};
   endfunction

   // The LFSR moves once for every bit that is taken.
   function automatic word_t rand_bits(input int count);
      word_t value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         value      = {value[XLEN-2:0], lfsr_state[0]};
      end
      return value;
   endfunction

   // Language division already truncates toward zero and gives the
   // remainder the sign of the dividend. The two special cases are
   // handled before it.
   function automatic word_t expected_result(input div_op_t kind, input word_t a,
                                             input word_t b);
      logic  is_signed;
      word_t quo;
      word_t rem;
      is_signed = (kind == op_div) || (kind == op_rem);
      if (b == '0) begin
         quo = '1;
         rem = a;
      end else if (is_signed && a == MOST_NEG && b == '1) begin
         quo = MOST_NEG;
         rem = '0;
      end else if (is_signed) begin
         quo = word_t'($signed(a) / $signed(b));
         rem = word_t'($signed(a) % $signed(b));
      end else begin
         quo = a / b;
         rem = a % b;
      end
      return (kind == op_rem || kind == op_remu) ? rem : quo;
   endfunction

   `include "ncpu32k_div_tests.svh"

   // -------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------

   initial begin
      reset      = 1'b1;
      in_valid   = 1'b0;
      op         = op_divu;
      dividend   = '0;
      divisor    = '0;
      out_ready  = 1'b0;
      lfsr_state = LFSR_SEED;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;

      test_reset_state();
      test_unsigned();
      test_signed();
      test_div_zero();
      test_latency();
      test_backpressure();

      $display("Checks passed: %0d, failed: %0d", pass_count, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* source/ncpu32k_div_unit.sv */
`timescale 1ns/1ps

// ----------------------------------------------------------------------
// Integer divide unit with buffered request and result ports.
// ----------------------------------------------------------------------

module ncpu32k_div_unit #(
   parameter bit PIPEBUF_BYPASS = 1'b1
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  ncpu32k_div_pkg::div_op_t op,
   input  ncpu32k_div_pkg::word_t   dividend,
   input  ncpu32k_div_pkg::word_t   divisor,
   output logic                     out_valid,
   input  logic                     out_ready,
   output ncpu32k_div_pkg::word_t   result,
   output logic                     retire
);
   import ncpu32k_div_pkg::*;

   // Request path.
   logic [REQ_W-1:0] req_din;
   logic [REQ_W-1:0] req_dout;
   logic             req_valid;
   logic             req_pop;
   div_op_t          req_op;
   word_t            req_dividend;
   word_t            req_divisor;

   // Sequencing.
   logic last;
   logic load;
   logic step;
   logic fix;

   // Result path.
   logic  res_valid;
   logic  res_ready;
   word_t res_word;

   // Operation on top, divisor at the bottom.
   assign req_din = {op, dividend, divisor};

   assign req_op       = div_op_t'(req_dout[REQ_W-1 -: OP_W]);
   assign req_dividend = req_dout[2*XLEN-1 -: XLEN];
   assign req_divisor  = req_dout[XLEN-1:0];

   // Holds the next request while the datapath is busy.
   ncpu32k_cell_pipebuf #(
      .DW            (REQ_W),
      .ENABLE_BYPASS (PIPEBUF_BYPASS)
   ) i_in_buf (
      .clk       (clk),
      .reset     (reset),
      .din       (req_din),
      .dout      (req_dout),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_valid (req_valid),
      .out_ready (req_pop),
      .cas       ()
   );

   ncpu32k_div_ctrl i_ctrl (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_pop   (req_pop),
      .last      (last),
      .load      (load),
      .step      (step),
      .fix       (fix),
      .res_valid (res_valid),
      .res_ready (res_ready)
   );

   ncpu32k_div_iter_counter i_iter_counter (
      .clk   (clk),
      .reset (reset),
      .load  (load),
      .step  (step),
      .last  (last)
   );

   ncpu32k_div_datapath i_datapath (
      .clk      (clk),
      .reset    (reset),
      .load     (load),
      .step     (step),
      .fix      (fix),
      .op       (req_op),
      .dividend (req_dividend),
      .divisor  (req_divisor),
      .result   (res_word)
   );

   // Holds a finished result until the consumer takes it.
   // Its push marks the result as retired.
   ncpu32k_cell_pipebuf #(
      .DW            (XLEN),
      .ENABLE_BYPASS (PIPEBUF_BYPASS)
   ) i_out_buf (
      .clk       (clk),
      .reset     (reset),
      .din       (res_word),
      .dout      (result),
      .in_valid  (res_valid),
      .in_ready  (res_ready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .cas       (retire)
   );

endmodule

/* source/ncpu32k_div_datapath.sv */
`timescale 1ns/1ps

// ----------------------------------------------------------------------
// Restoring shift-subtract divider datapath.
// ----------------------------------------------------------------------

module ncpu32k_div_datapath (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     load,
   input  logic                     step,
   input  logic                     fix,
   input  ncpu32k_div_pkg::div_op_t op,
   input  ncpu32k_div_pkg::word_t   dividend,
   input  ncpu32k_div_pkg::word_t   divisor,
   output ncpu32k_div_pkg::word_t   result
);
   import ncpu32k_div_pkg::*;

   // Operand conditioning.
   logic  is_signed;
   logic  dividend_neg;
   logic  divisor_neg;
   word_t dividend_abs;
   word_t divisor_abs;

   // Iteration state.
   word_t quo_q;
   word_t rem_q;
   word_t dsr_q;
   word_t dividend_q;

   // Fix-up flags captured with the operands.
   div_op_t op_q;
   logic    quo_neg_q;
   logic    rem_neg_q;
   logic    div_zero_q;

   // One step of the division.
   logic [XLEN:0] shifted;
   logic [XLEN:0] diff;
   logic          fits;

   // Final selection.
   word_t quo_fixed;
   word_t rem_fixed;
   word_t res_nxt;
   word_t result_q;

   // -------------------------------------------------------------------
   // Operand conditioning
   // -------------------------------------------------------------------

   assign is_signed    = (op == op_div) || (op == op_rem);
   assign dividend_neg = is_signed & dividend[XLEN-1];
   assign divisor_neg  = is_signed & divisor[XLEN-1];

   // The most negative number stays 0x80000000 here, which is its
   // correct magnitude when read as unsigned.
   assign dividend_abs = dividend_neg ? -dividend : dividend;
   assign divisor_abs  = divisor_neg ? -divisor : divisor;

   always_ff @(posedge clk) begin
      if (reset) begin
         op_q       <= op_divu;
         quo_neg_q  <= 1'b0;
         rem_neg_q  <= 1'b0;
         div_zero_q <= 1'b0;
      end else if (load) begin
         op_q       <= op;
         quo_neg_q  <= dividend_neg ^ divisor_neg;
         // The remainder follows the sign of the dividend.
         rem_neg_q  <= dividend_neg;
         div_zero_q <= (divisor == '0);
      end
   end

   // -------------------------------------------------------------------
   // Shift-subtract step
   // -------------------------------------------------------------------

   // The next dividend bit enters the partial remainder from the top of
   // the quotient register, and the new quotient bit enters at the bottom.
   assign shifted = {rem_q, quo_q[XLEN-1]};
   assign diff    = shifted - {1'b0, dsr_q};
   assign fits    = (shifted >= {1'b0, dsr_q});

   always_ff @(posedge clk) begin
      if (load) begin
         quo_q      <= dividend_abs;
         rem_q      <= '0;
         dsr_q      <= divisor_abs;
         dividend_q <= dividend;
      end else if (step) begin
         rem_q <= fits ? diff[XLEN-1:0] : shifted[XLEN-1:0];
         quo_q <= {quo_q[XLEN-2:0], fits};
      end
   end

   // -------------------------------------------------------------------
   // Sign and zero fix-up
   // -------------------------------------------------------------------

   // Negating the magnitudes truncates the quotient toward zero.
   assign quo_fixed = quo_neg_q ? -quo_q : quo_q;
   assign rem_fixed = rem_neg_q ? -rem_q : rem_q;

   always_comb begin
      case (op_q)
         op_div, op_divu: res_nxt = div_zero_q ? '1 : quo_fixed;
         default:         res_nxt = div_zero_q ? dividend_q : rem_fixed;
      endcase
   end

   always_ff @(posedge clk) begin
      if (fix) begin
         result_q <= res_nxt;
      end
   end

   assign result = result_q;

endmodule

/* source/ncpu32k_div_iter_counter.sv */
`timescale 1ns/1ps

// ----------------------------------------------------------------------
// Step counter of the divide unit.
// ----------------------------------------------------------------------

module ncpu32k_div_iter_counter (
   input  logic clk,
   input  logic reset,
   input  logic load,
   input  logic step,
   output logic last
);
   import ncpu32k_div_pkg::*;

   iter_cnt_t count;

   // Set once the final step has been taken, cleared by the next load.
   logic spent;

   // The count starts at one less than the number of steps, so it
   // reaches zero during the last one.
   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
         spent <= 1'b1;
      end else if (load) begin
         count <= iter_cnt_t'(XLEN - 1);
         spent <= 1'b0;
      end else if (step) begin
         if (count != '0) begin
            count <= count - 1'b1;
         end else begin
            spent <= 1'b1;
         end
      end
   end

   assign last = (count == '0);

   // A run of steps must stop once its last step is used up.
   a_no_extra_step : assert property (@(posedge clk) disable iff (reset)
      step |-> !spent);

endmodule

/* source/ncpu32k_div_ctrl.sv */
`timescale 1ns/1ps

// ----------------------------------------------------------------------
// Sequencer of the divide unit.
// ----------------------------------------------------------------------

module ncpu32k_div_ctrl (
   input  logic clk,
   input  logic reset,
   input  logic req_valid,
   output logic req_pop,
   input  logic last,
   output logic load,
   output logic step,
   output logic fix,
   output logic res_valid,
   input  logic res_ready
);
   import ncpu32k_div_pkg::*;

   // Idle waits for a request, iterate runs the shift-subtract steps,
   // finish applies the signs and done offers the result downstream.
   typedef enum logic [1:0] {
      st_idle,
      st_iterate,
      st_finish,
      st_done
   } state_t;

   state_t state;
   state_t state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (req_valid) begin
               state_nxt = st_iterate;
            end
         end
         st_iterate: begin
            // The step flagged by last is the final quotient bit.
            if (last) begin
               state_nxt = st_finish;
            end
         end
         st_finish: begin
            state_nxt = st_done;
         end
         st_done: begin
            if (res_ready) begin
               state_nxt = st_idle;
            end
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // The request leaves the input buffer in the cycle its operands load.
   assign req_pop = (state == st_idle) & req_valid;
   assign load    = req_pop;

   assign step      = (state == st_iterate);
   assign fix       = (state == st_finish);
   assign res_valid = (state == st_done);

   // Each load is followed by exactly one step per quotient bit and then
   // a single fix. This checks the counter against the sequencer.
   a_step_run : assert property (@(posedge clk) disable iff (reset)
      load |=> step [*XLEN] ##1 (fix && !step));

endmodule

/* source/ncpu32k_cell_pipebuf.sv */
`timescale 1ns/1ps

// ----------------------------------------------------------------------
// One-slot pipe buffer with a valid/ready handshake on both sides.
// ----------------------------------------------------------------------

module ncpu32k_cell_pipebuf #(
   parameter int DW            = 1,
   parameter bit ENABLE_BYPASS = 1'b1
) (
   input  logic          clk,
   input  logic          reset,
   input  logic [DW-1:0] din,
   output logic [DW-1:0] dout,
   input  logic          in_valid,
   output logic          in_ready,
   output logic          out_valid,
   input  logic          out_ready,
   output logic          cas
);

   logic push;
   logic pop;

   // A transfer on either side happens when valid meets ready.
   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   // The slot is full after a push and empty after a pop alone.
   // Push and pop on the same edge leave it full with the new word.
   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (push | pop) begin
         out_valid <= push;
      end
   end

   // The data word only moves on a push.
   always_ff @(posedge clk) begin
      if (push) begin
         dout <= din;
      end
   end

   // With bypass the slot takes a new word in the cycle it is emptied.
   if (ENABLE_BYPASS) begin : g_bypass
      assign in_ready = ~out_valid | pop;
   end else begin : g_no_bypass
      assign in_ready = ~out_valid;
   end

   assign cas = push;

   // A sender must hold its valid and its word until the slot takes it.
   a_din_stable : assert property (@(posedge clk) disable iff (reset)
      (in_valid && !in_ready) |=> (in_valid && $stable(din)));

endmodule

/* source/ncpu32k_div_pkg.sv */
// ----------------------------------------------------------------------
// Shared types of the integer divide unit.
// ----------------------------------------------------------------------

package ncpu32k_div_pkg;

   // Width of one operand and of one result.
   localparam int XLEN = 32;

   // Width of the operation code.
   localparam int OP_W = 2;

   // Width of the iteration counter. One count per quotient bit.
   localparam int ITER_W = $clog2(XLEN);

   // One operand or result word.
   typedef logic [XLEN-1:0] word_t;

   // Remaining division steps.
   typedef logic [ITER_W-1:0] iter_cnt_t;

   // Operations of the unit.
   // Bit 0 marks an unsigned operation and bit 1 selects the remainder.
   typedef enum logic [OP_W-1:0] {
      op_div  = 2'b00,
      op_divu = 2'b01,
      op_rem  = 2'b10,
      op_remu = 2'b11
   } div_op_t;

   // A packed request holds the operation on top, then the dividend,
   // then the divisor in the low word.
   localparam int REQ_W = OP_W + 2 * XLEN;

endpackage
